//--- analog_top.f
rtl/analog_pkg.sv
rtl/adc_front.sv
rtl/dac_back.sv
rtl/sys_bus_decoder.sv
rtl/housekeeping_regs.sv
rtl/analog_top.sv
verif/tb_clock_gen.sv
verif/analog_tb.sv

//--- Makefile
# Verilator lint and simulation of the analog top level

VERILATOR  ?= verilator
TOP        := analog_tb
RTL_TOP    := analog_top
FILELIST   := analog_top.f
LOG        := sim.log
PASS_MSG   := Test OK

LINT_FLAGS := --lint-only --timing
# warnings are still printed, they just do not stop the build
SIM_FLAGS  := --binary --timing -Wno-fatal
SIM_EXE    := obj_dir/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./$(SIM_EXE) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verif/analog_input.txt
# name kind chan f1 f2 expected, numbers in hex
# adc: f1 raw code | dac/loop: f1 asg, f2 pid | wr/rd: f1 address, f2 wdata, expected led or rdata
adc_zero_a        adc  a 1FFF 0000 0000
adc_pos_fs_a      adc  a 0000 0000 1FFF
adc_neg_fs_a      adc  a 3FFF 0000 2000
adc_pos_fs_b      adc  b 0000 0000 1FFF
adc_neg_fs_b      adc  b 3FFF 0000 2000
adc_mid_pos_a     adc  a 0FFF 0000 1000
adc_mid_neg_b     adc  b 2FFF 0000 3000
adc_misc_a        adc  a 1234 0000 0DCB
adc_misc_b        adc  b 3A5C 0000 25A3
dac_zero_a        dac  a 0000 0000 1FFF
dac_small_a       dac  a 0064 00C8 1ED3
dac_neg_b         dac  b 3F9C 3F38 212B
dac_max_a         dac  a 1FFF 0000 0000
dac_pos_ovf_a     dac  a 1FFF 0001 0000
dac_pos_ovf_b     dac  b 1800 1000 0000
dac_neg_ovf_a     dac  a 2000 3FFF 3FFF
dac_neg_ovf_b     dac  b 2000 2000 3FFF
dac_edge_a        dac  a 1000 0FFF 0000
hk_id_rd          rd   - 00000000 00000000 C0DE4A17
hk_loop_rd0       rd   - 00000004 00000000 00000000
hk_led_wr         wr   - 00000008 000000A5 000000A5
hk_led_rd         rd   - 00000008 00000000 000000A5
hk_led_wr2        wr   - 00000008 FFFFFF3C 0000003C
hk_led_rd2        rd   - 00000008 00000000 0000003C
hk_unmapped_rd    rd   - 0000000C 00000000 00000000
un1_rd            rd   - 00100000 00000000 00000000
un3_rd            rd   - 00300008 00000000 00000000
un7_rd            rd   - 00700004 00000000 00000000
un2_wr            wr   - 00200008 00000055 0000003C
un5_wr            wr   - 00500004 00000001 0000003C
un_loop_rd        rd   - 00000004 00000000 00000000
loop_on           wr   - 00000004 00000001 0000003C
loop_rd           rd   - 00000004 00000000 00000001
loop_a            loop a 0064 00C8 012C
loop_b            loop b 3F9C 3F38 3ED4
loop_pos_sat_a    loop a 1FFF 0001 1FFF
loop_neg_sat_b    loop b 2000 3FFF 2000
loop_off          wr   - 00000004 00000000 0000003C
adc_after_loop_a  adc  a 0000 0000 1FFF
adc_after_loop_b  adc  b 3FFF 0000 2000

//--- verif/analog_tb.sv
/* testbench for analog_top that replays the records of the stimulus file on
   the ADC, DAC, bus and loopback paths and compares with the expected values */

`timescale 1ns/1ps

module analog_tb import analog_pkg::*; ();

  localparam int        CLK_PERIOD   = 100;
  localparam int        RESET_CYCLES = 16;
  localparam int        DRIVE_DLY    = 2;   // ns after rising edge
  localparam int        ACK_LIMIT    = 8;   // cycles before giving up
  localparam int        REC_CYCLES   = 20;  // watchdog budget per record
  localparam bus_word_t TB_HK_ID     = 32'hC0DE_4A17;
  localparam string     INPUT_FILE   = "verif/analog_input.txt";

  logic        adc_clk;
  logic        reset_i;
  logic [15:0] adc_dat_a_i;
  logic [15:0] adc_dat_b_i;
  adc_sample_t asg_a_i;
  adc_sample_t asg_b_i;
  adc_sample_t pid_a_i;
  adc_sample_t pid_b_i;
  adc_sample_t adc_a_o;
  adc_sample_t adc_b_o;
  dac_code_t   dac_a_o;
  dac_code_t   dac_b_o;
  bus_word_t   sys_addr_i;
  bus_word_t   sys_wdata_i;
  bus_word_t   sys_rdata_o;
  logic [3:0]  sys_sel_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  logic        sys_ack_o;
  led_t        led_o;

  // record fields filled once from the file
  string       rec_name [$];
  string       rec_kind [$];
  string       rec_chan [$];
  bus_word_t   rec_f1   [$];
  bus_word_t   rec_f2   [$];
  bus_word_t   rec_exp  [$];
  bit          records_loaded = 1'b0;
  longint      watchdog_ns;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
    .clk_o   (adc_clk),
    .reset_o (reset_i)
  );

  analog_top #(.HK_ID(TB_HK_ID)) i_analog_top (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .asg_a_i     (asg_a_i),
    .asg_b_i     (asg_b_i),
    .pid_a_i     (pid_a_i),
    .pid_b_i     (pid_b_i),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_sel_i   (sys_sel_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .led_o       (led_o)
  );

  // ----------------------------------------------------------
  // failure reporting and compares
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_sample(input string name, input adc_sample_t exp, input adc_sample_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_code(input string name, input dac_code_t exp, input dac_code_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin  // ack delay in cycles after the strobe
      $display("CHECK FAILED %s expected ack after %0d cycles actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // stimulus file
  // ----------------------------------------------------------
  task automatic load_records();
    int        fd;
    int        n;
    string     line;
    string     name;
    string     kind;
    string     chan;
    bus_word_t f1;
    bus_word_t f2;
    bus_word_t ex;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("could not open stimulus file %s", INPUT_FILE);
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // skip comments and blanks
        n = $sscanf(line, "%s %s %s %h %h %h", name, kind, chan, f1, f2, ex);
        if (n != 6) begin
          $display("malformed record in %s: %s", INPUT_FILE, line);
          abort_run();
        end
        rec_name.push_back(name);
        rec_kind.push_back(kind);
        rec_chan.push_back(chan);
        rec_f1.push_back(f1);
        rec_f2.push_back(f2);
        rec_exp.push_back(ex);
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------
  // per-kind record runners
  // ----------------------------------------------------------
  task automatic run_adc(input string name, input bit use_b, input bus_word_t code,
                         input bus_word_t exp);
    dac_code_t other;
    other = dac_code_t'($urandom);       // unnamed channel gets noise
    @(posedge adc_clk);
    #(DRIVE_DLY);
    adc_dat_a_i = {use_b ? other : code[ADC_W-1:0], 2'($urandom)};  // low bits unused
    adc_dat_b_i = {use_b ? code[ADC_W-1:0] : other, 2'($urandom)};
    @(posedge adc_clk);                  // capture edge
    @(negedge adc_clk);
    check_sample(name, exp[ADC_W-1:0], use_b ? adc_b_o : adc_a_o);
  endtask

  // drive generator and controller values with the other channel random
  task automatic drive_sums(input bit use_b, input bus_word_t asg, input bus_word_t pid);
    @(posedge adc_clk);
    #(DRIVE_DLY);
    asg_a_i = use_b ? adc_sample_t'($urandom) : asg[ADC_W-1:0];
    pid_a_i = use_b ? adc_sample_t'($urandom) : pid[ADC_W-1:0];
    asg_b_i = use_b ? asg[ADC_W-1:0] : adc_sample_t'($urandom);
    pid_b_i = use_b ? pid[ADC_W-1:0] : adc_sample_t'($urandom);
  endtask

  task automatic run_dac(input string name, input bit use_b, input bus_word_t asg,
                         input bus_word_t pid, input bus_word_t exp);
    drive_sums(use_b, asg, pid);
    @(posedge adc_clk);                  // output register loads
    @(negedge adc_clk);
    check_code(name, exp[ADC_W-1:0], use_b ? dac_b_o : dac_a_o);
  endtask

  task automatic run_loop(input string name, input bit use_b, input bus_word_t asg,
                          input bus_word_t pid, input bus_word_t exp);
    drive_sums(use_b, asg, pid);
    adc_dat_a_i = 16'($urandom);         // pins must not show through
    adc_dat_b_i = 16'($urandom);
    @(negedge adc_clk);                  // loop path is combinational
    check_sample(name, exp[ADC_W-1:0], use_b ? adc_b_o : adc_a_o);
  endtask

  // one bus transfer with the strobe held a single cycle and the ack delay returned
  task automatic bus_access(input string name, input bit is_write, input bus_word_t addr,
                            input bus_word_t wdata, output bus_word_t rdata, output int waited);
    @(posedge adc_clk);
    #(DRIVE_DLY);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_sel_i   = 4'hF;
    sys_wen_i   = is_write;
    sys_ren_i   = !is_write;
    waited      = 0;
    @(negedge adc_clk);
    while (!sys_ack_o && waited < ACK_LIMIT) begin
      @(posedge adc_clk);
      #(DRIVE_DLY);
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      @(negedge adc_clk);
      waited++;
    end
    if (sys_ack_o !== 1'b1) begin
      $display("%s: no acknowledge within %0d cycles of the bus strobe", name, ACK_LIMIT);
      abort_run();
    end
    rdata = sys_rdata_o;
    if (waited == 0) begin               // same-cycle ack leaves the strobe still up
      @(posedge adc_clk);
      #(DRIVE_DLY);
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
    end
  endtask

  task automatic run_bus(input string name, input bit is_write, input bus_word_t addr,
                         input bus_word_t wdata, input bus_word_t exp);
    bus_word_t rdata;
    int        waited;
    int        exp_wait;
    // region 0 answers a cycle late and free regions at once
    exp_wait = (addr[REGION_MSB:REGION_LSB] == 3'd0) ? 1 : 0;
    bus_access(name, is_write, addr, wdata, rdata, waited);
    check_latency(name, exp_wait, waited);
    if (is_write)
      check_led(name, exp[7:0], led_o);
    else
      check_word(name, exp, rdata);
  endtask

  // ----------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------
  initial begin
    wait (records_loaded);
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    abort_run();
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    bit use_b;
    void'($urandom(99139));
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;

    load_records();
    watchdog_ns    = longint'(rec_name.size() * REC_CYCLES + RESET_CYCLES + 4) * CLK_PERIOD;
    records_loaded = 1'b1;

    wait (reset_i === 1'b1);
    wait (reset_i === 1'b0);
    @(negedge adc_clk);                  // no edge since release yet
    check_led("reset_led", 8'h00, led_o);
    check_code("reset_dac_a", 14'h1FFF, dac_a_o);  // zero volts
    check_code("reset_dac_b", 14'h1FFF, dac_b_o);
    if (sys_ack_o !== 1'b0) begin
      $display("CHECK FAILED reset_ack expected 0 actual %b", sys_ack_o);
      abort_run();
    end

    foreach (rec_name[i]) begin
      use_b = (rec_chan[i] == "b");
      case (rec_kind[i])
        "adc":  run_adc(rec_name[i], use_b, rec_f1[i], rec_exp[i]);
        "dac":  run_dac(rec_name[i], use_b, rec_f1[i], rec_f2[i], rec_exp[i]);
        "loop": run_loop(rec_name[i], use_b, rec_f1[i], rec_f2[i], rec_exp[i]);
        "wr":   run_bus(rec_name[i], 1'b1, rec_f1[i], rec_f2[i], rec_exp[i]);
        "rd":   run_bus(rec_name[i], 1'b0, rec_f1[i], rec_f2[i], rec_exp[i]);
        default: begin
          $display("record %s has unknown kind %s", rec_name[i], rec_kind[i]);
          abort_run();
        end
      endcase
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- verif/tb_clock_gen.sv
/* testbench clock and reset source: free-running adc_clk and a
   synchronous reset held for a fixed number of rising edges */

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16,
  parameter int RELEASE_DLY  = 2   // same offset as the stimulus
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(RELEASE_DLY) reset_o = 1'b0;  // released just after an edge
  end

endmodule

//--- rtl/analog_top.sv
/* analog top level: ADC front end, DAC back end, bus decoder and
   housekeeping registers, all on adc_clk; generator/controller via ports */

`timescale 1ns/1ps

module analog_top import analog_pkg::*; #(
  parameter bus_word_t HK_ID = 32'h0A11_0001  // passed to housekeeping
) (
  input  logic        adc_clk,
  input  logic        reset_i,
  // ADC pins, low two bits unused on a 14-bit part
  input  logic [15:0] adc_dat_a_i,
  input  logic [15:0] adc_dat_b_i,
  // generator and controller values
  input  adc_sample_t asg_a_i,
  input  adc_sample_t asg_b_i,
  input  adc_sample_t pid_a_i,
  input  adc_sample_t pid_b_i,
  // converted samples
  output adc_sample_t adc_a_o,
  output adc_sample_t adc_b_o,
  // DAC pins
  output dac_code_t   dac_a_o,
  output dac_code_t   dac_b_o,
  // system bus
  input  bus_word_t   sys_addr_i,
  input  bus_word_t   sys_wdata_i,
  input  logic [3:0]  sys_sel_i,
  input  logic        sys_wen_i,
  input  logic        sys_ren_i,
  output bus_word_t   sys_rdata_o,
  output logic        sys_ack_o,
  // status LEDs
  output led_t        led_o
);

  // ----------------------------------------------------------
  // local signals
  // ----------------------------------------------------------
  adc_sample_t sum_a;      // clamped dac sums, loopback source
  adc_sample_t sum_b;
  logic        loop_en;    // digital loop from housekeeping
  logic        hk_wen;
  logic        hk_ren;
  bus_word_t   hk_rdata;
  logic        hk_ack;

  // ----------------------------------------------------------
  // analog path
  // ----------------------------------------------------------
  adc_front i_adc_front (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .raw_a_i   (adc_dat_a_i[15:2]),  // msb-aligned 14 bits
    .raw_b_i   (adc_dat_b_i[15:2]),
    .loop_en_i (loop_en),
    .loop_a_i  (sum_a),
    .loop_b_i  (sum_b),
    .adc_a_o   (adc_a_o),
    .adc_b_o   (adc_b_o)
  );

  dac_back i_dac_back (
    .adc_clk (adc_clk),
    .reset_i (reset_i),
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .sum_a_o (sum_a),
    .sum_b_o (sum_b),
    .dac_a_o (dac_a_o),
    .dac_b_o (dac_b_o)
  );

  // ----------------------------------------------------------
  // system bus
  // ----------------------------------------------------------
  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack)
  );

  housekeeping_regs #(
    .HK_ID (HK_ID)
  ) i_housekeeping_regs (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .addr_i    (sys_addr_i),   // full address, block looks at offset
    .wdata_i   (sys_wdata_i),
    .sel_i     (sys_sel_i),
    .wen_i     (hk_wen),
    .ren_i     (hk_ren),
    .rdata_o   (hk_rdata),
    .ack_o     (hk_ack),
    .loop_en_o (loop_en),
    .led_o     (led_o)
  );

endmodule

//--- rtl/housekeeping_regs.sv
/* housekeeping register block on bus region 0: ID word, digital loop
   enable and LED pattern; every strobe is acknowledged one cycle later */

`timescale 1ns/1ps

module housekeeping_regs import analog_pkg::*; #(
  parameter bus_word_t HK_ID = 32'h0A11_0001  // board/design identifier
) (
  input  logic       adc_clk,
  input  logic       reset_i,
  // bus slave port
  input  bus_word_t  addr_i,
  input  bus_word_t  wdata_i,
  input  logic [3:0] sel_i,     // byte selects
  input  logic       wen_i,
  input  logic       ren_i,
  output bus_word_t  rdata_o,
  output logic       ack_o,
  // configuration outputs
  output logic       loop_en_o,
  output led_t       led_o
);

  logic [REGION_LSB-1:0] ofs;  // offset inside the region
  logic                  loop_en_q;
  led_t                  led_q;

  assign ofs = addr_i[REGION_LSB-1:0];

  // ----------------------------------------------------------
  // writable registers
  // ----------------------------------------------------------
  // both fields sit in byte 0, so only sel_i[0] matters
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      loop_en_q <= 1'b0;
      led_q     <= '0;
    end else if (wen_i && sel_i[0]) begin
      if (ofs == HK_LOOP_OFS)
        loop_en_q <= wdata_i[0];
      if (ofs == HK_LED_OFS)
        led_q <= wdata_i[7:0];
      // writes to the ID or unmapped offsets are dropped
    end
  end

  // ----------------------------------------------------------
  // read data and acknowledge
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;  // single-cycle pulse, one after strobe
  end

  // read data lines up with ack
  always_ff @(posedge adc_clk) begin
    if (ren_i) begin
      case (ofs)
        HK_ID_OFS:   rdata_o <= HK_ID;
        HK_LOOP_OFS: rdata_o <= {{(BUS_W-1){1'b0}}, loop_en_q};
        HK_LED_OFS:  rdata_o <= {{(BUS_W-8){1'b0}}, led_q};
        default:     rdata_o <= '0;  // unmapped reads as zero
      endcase
    end
  end

  assign loop_en_o = loop_en_q;
  assign led_o     = led_q;

endmodule

//--- rtl/sys_bus_decoder.sv
/* system bus decoder: splits the address space into eight regions, steers
   the strobes to housekeeping and answers the free regions with zero data */

`timescale 1ns/1ps

module sys_bus_decoder import analog_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  // master side
  input  bus_word_t sys_addr_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_word_t sys_rdata_o,
  output logic      sys_ack_o,
  // housekeeping slave, region 0
  output logic      hk_wen_o,
  output logic      hk_ren_o,
  input  bus_word_t hk_rdata_i,
  input  logic      hk_ack_i
);

  region_t             region;
  logic [REGION_N-1:0] cs;                   // one-hot region select
  logic [REGION_N-1:0] ack_vec;              // per-region acknowledge
  bus_word_t           rdata_vec [REGION_N]; // per-region read data
  logic                unused_ack_en;        // free slots may answer

  // ----------------------------------------------------------
  // region select
  // ----------------------------------------------------------
  assign region = sys_addr_i[REGION_MSB:REGION_LSB];
  assign cs     = {{(REGION_N-1){1'b0}}, 1'b1} << region;

  // strobes only reach the slave that owns the address
  assign hk_wen_o = sys_wen_i & cs[HK_REGION];
  assign hk_ren_o = sys_ren_i & cs[HK_REGION];

  // hold off the free-slot ack until reset is released
  always_ff @(posedge adc_clk) begin
    if (reset_i)
      unused_ack_en <= 1'b0;
    else
      unused_ack_en <= 1'b1;
  end

  // ----------------------------------------------------------
  // slave responses
  // ----------------------------------------------------------
  for (genvar r = 0; r < REGION_N; r++) begin : g_region
    if (r == HK_REGION) begin : g_hk
      assign ack_vec[r]   = hk_ack_i;    // one cycle after strobe
      assign rdata_vec[r] = hk_rdata_i;
    end else begin : g_unused
      // nothing behind this slot, ack at once with zero
      assign ack_vec[r]   = unused_ack_en & (sys_wen_i | sys_ren_i);
      assign rdata_vec[r] = '0;
    end
  end

  // ----------------------------------------------------------
  // return mux, follows the current address
  // ----------------------------------------------------------
  assign sys_ack_o   = |(cs & ack_vec);
  assign sys_rdata_o = rdata_vec[region];

endmodule

//--- rtl/dac_back.sv
/* DAC output stage that adds generator and controller values per channel,
   clamps to 14 bits and registers the negative-slope code for the pins */

`timescale 1ns/1ps

module dac_back import analog_pkg::*; (
  input  logic        adc_clk,
  input  logic        reset_i,
  // generator and controller contributions
  input  adc_sample_t asg_a_i,
  input  adc_sample_t asg_b_i,
  input  adc_sample_t pid_a_i,
  input  adc_sample_t pid_b_i,
  // clamped sums that also feed the loopback
  output adc_sample_t sum_a_o,
  output adc_sample_t sum_b_o,
  // converter codes
  output dac_code_t   dac_a_o,
  output dac_code_t   dac_b_o
);

  logic signed [SUM_W-1:0] sum_a;  // one guard bit for overflow
  logic signed [SUM_W-1:0] sum_b;

  // clamp the widened sum back into the sample range
  function automatic adc_sample_t saturate(input logic signed [SUM_W-1:0] sum);
    logic sgn;
    sgn = sum[SUM_W-1];
    if (sum[SUM_W-1] ^ sum[SUM_W-2])  // top two bits disagree on overflow
      return adc_sample_t'({sgn, {(ADC_W-1){~sgn}}});  // +8191 or -8192
    else
      return sum[ADC_W-1:0];
  endfunction

  // ----------------------------------------------------------
  // summing and saturation
  // ----------------------------------------------------------
  assign sum_a = asg_a_i + pid_a_i;  // operands sign-extend to SUM_W
  assign sum_b = asg_b_i + pid_b_i;

  assign sum_a_o = saturate(sum_a);
  assign sum_b_o = saturate(sum_b);

  // ----------------------------------------------------------
  // output register and neg-slope code conversion
  // ----------------------------------------------------------
  // the same self-inverse bit flip as on the ADC side
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_a_o <= 14'h1FFF;  // code for zero output
      dac_b_o <= 14'h1FFF;
    end else begin
      dac_a_o <= {sum_a_o[ADC_W-1], ~sum_a_o[ADC_W-2:0]};
      dac_b_o <= {sum_b_o[ADC_W-1], ~sum_b_o[ADC_W-2:0]};
    end
  end

endmodule

//--- rtl/adc_front.sv
/* ADC input stage: registers both raw channels, turns the negative-slope
   code into two's complement and swaps in the DAC sums in digital loopback */

`timescale 1ns/1ps

module adc_front import analog_pkg::*; (
  input  logic        adc_clk,
  input  logic        reset_i,
  // raw converter bits, already sliced to 14
  input  dac_code_t   raw_a_i,
  input  dac_code_t   raw_b_i,
  // loopback from the dac side
  input  logic        loop_en_i,
  input  adc_sample_t loop_a_i,
  input  adc_sample_t loop_b_i,
  // samples to the rest of the system
  output adc_sample_t adc_a_o,
  output adc_sample_t adc_b_o
);

  dac_code_t   raw_a_q;  // input registers, ideally packed into the IOB
  dac_code_t   raw_b_q;
  adc_sample_t conv_a;
  adc_sample_t conv_b;

  // ----------------------------------------------------------
  // input capture
  // ----------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= raw_a_i;
      raw_b_q <= raw_b_i;
    end
  end

  // ----------------------------------------------------------
  // format conversion and loop select
  // ----------------------------------------------------------
  // keep msb, flip the rest -> two's complement
  assign conv_a = adc_sample_t'({raw_a_q[ADC_W-1], ~raw_a_q[ADC_W-2:0]});
  assign conv_b = adc_sample_t'({raw_b_q[ADC_W-1], ~raw_b_q[ADC_W-2:0]});

  // loopback path is unregistered, follows the current sums
  assign adc_a_o = loop_en_i ? loop_a_i : conv_a;
  assign adc_b_o = loop_en_i ? loop_b_i : conv_b;

endmodule

//--- rtl/analog_pkg.sv
/* shared widths, sample/code types and bus map for the analog top level
   imported by every rtl block that needs a type or constant from here */

package analog_pkg;

  // ----------------------------------------------------------
  // data path widths and types
  // ----------------------------------------------------------
  localparam int ADC_W = 14;  // converter sample width
  localparam int SUM_W = 15;  // asg + pid before clamp
  localparam int BUS_W = 32;  // system bus addr/data

  typedef logic signed [ADC_W-1:0] adc_sample_t;  // two's complement
  typedef logic        [ADC_W-1:0] dac_code_t;    // neg-slope offset code
  typedef logic        [BUS_W-1:0] bus_word_t;
  typedef logic        [7:0]       led_t;

  // ----------------------------------------------------------
  // system bus region decode
  // ----------------------------------------------------------
  localparam int REGION_N   = 8;
  localparam int REGION_LSB = 20;  // region field lives in addr[22:20]
  localparam int REGION_MSB = 22;

  typedef logic [REGION_MSB-REGION_LSB:0] region_t;

  localparam region_t HK_REGION = region_t'(0);  // housekeeping slot

  // housekeeping byte offsets, compared against addr below the region field
  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 'h00;  // read only
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 'h04;  // bit 0 = digital loop
  localparam logic [REGION_LSB-1:0] HK_LED_OFS  = 'h08;  // led pattern

endpackage
